/* sources.f */
src/pwmPkg.sv
src/pwmChanIf.sv
src/clkEnableDivider.sv
src/dutyGenerator.sv
src/pwmRegBank.sv
src/pwmSubsystem.sv
tests/pwmSubsystem_properties.sv
tests/pwmSubsystemTb.sv

/* tests/pwmSubsystemTb.sv */
//----------------------------------------------------------------------
// PWM subsystem testbench
// Directed AXI4-Lite register, duty, status and bus error tests
//----------------------------------------------------------------------
module pwmSubsystemTb;
	timeunit 1ns;
	timeprecision 1ps;

	logic             iSysClk;
	logic             rstN;
	pwmPkg::addrT     awAddr;
	pwmPkg::addrT     arAddr;
	pwmPkg::dataT     wData;
	pwmPkg::dataT     rData;
	logic [3:0]       wStrb;
	logic             awValid;    // Host drives
	logic             wValid;
	logic             bReady;
	logic             arValid;
	logic             rReady;
	logic             awReady;    // DUT drives
	logic             wReady;
	logic             bValid;
	logic             arReady;
	logic             rValid;
	logic [1:0]       bResp;
	logic [1:0]       rResp;
	pwmPkg::chanMaskT pwm;
	logic             irq;

	int errCount;
	int timeoutCount;
	int dutySet [pwmPkg::NumChannels];   // Programmed duty per channel
	int divSet  [pwmPkg::NumChannels];   // Programmed divisor per channel

	pwmSubsystem DUT (.*);

	always #50 iSysClk = ~iSysClk;       // 100 ns period

	//------------------------------------------------------------------
	// Helpers
	//------------------------------------------------------------------
	function automatic pwmPkg::addrT regAddr(input int c, input int off);
		return pwmPkg::addrT'(c * pwmPkg::ChanStride + off);
	endfunction

	task automatic checkVal(input string name, input pwmPkg::dataT expected,
		input pwmPkg::dataT actual);
		if (actual !== expected)
		begin
			$display("FAILED at %0t: %s expected 0x%0h, got 0x%0h",
				$time, name, expected, actual);
			errCount++;
		end
	endtask

	function automatic logic sampleSig(input string sigName);
		case (sigName)
			"awReady": return awReady && wReady;
			"bValid":  return bValid;
			"arReady": return arReady;
			"rValid":  return rValid;
			default:   return irq;
		endcase
	endfunction

	// Polls at falling edges, gives up after limit cycles
	task automatic awaitLevel(input string sigName, input logic level, input int limit);
		int n;
		n = 0;
		do
		begin
			@(negedge iSysClk);
			n++;
		end
		while (sampleSig(sigName) !== level && n < limit);
		if (sampleSig(sigName) !== level)
		begin
			$display("Timeout at %0t: %s did not go to %b within %0d cycles",
				$time, sigName, level, limit);
			timeoutCount++;
		end
	endtask

	//------------------------------------------------------------------
	// AXI4-Lite host
	//------------------------------------------------------------------
	task automatic axiWrite(input pwmPkg::addrT addr, input pwmPkg::dataT data,
		output logic [1:0] resp);
		@(posedge iSysClk);
		awAddr  <= addr;
		wData   <= data;
		awValid <= 1'b1;
		wValid  <= 1'b1;
		awaitLevel("awReady", 1'b1, 20);
		@(posedge iSysClk);                 // Handshake edge
		awValid <= 1'b0;
		wValid  <= 1'b0;
		awaitLevel("bValid", 1'b1, 20);
		resp = bResp;                       // Accepted on next rising edge
	endtask

	task automatic axiRead(input pwmPkg::addrT addr, output pwmPkg::dataT data,
		output logic [1:0] resp);
		@(posedge iSysClk);
		arAddr  <= addr;
		arValid <= 1'b1;
		awaitLevel("arReady", 1'b1, 20);
		@(posedge iSysClk);
		arValid <= 1'b0;
		awaitLevel("rValid", 1'b1, 20);
		data = rData;
		resp = rResp;
	endtask

	task automatic writeOk(input pwmPkg::addrT addr, input pwmPkg::dataT data);
		logic [1:0] resp;
		axiWrite(addr, data, resp);
		checkVal("bResp", pwmPkg::RespOkay, resp);
	endtask

	task automatic readCheck(input pwmPkg::addrT addr, input pwmPkg::dataT expected,
		input string name);
		pwmPkg::dataT data;
		logic [1:0]   resp;
		axiRead(addr, data, resp);
		checkVal(name, expected, data);
		checkVal("rResp", pwmPkg::RespOkay, resp);
	endtask

	// High cycles of one channel over a window
	task automatic countHigh(input int ch, input int cycles, output int highs);
		highs = 0;
		repeat (cycles)
		begin
			@(negedge iSysClk);
			if (pwm[ch])
				highs++;
		end
	endtask

	//------------------------------------------------------------------
	// Tests
	//------------------------------------------------------------------
	task automatic testRegisters();
		pwmPkg::dataT v;
		checkVal("outputs after reset", 0, {awReady, wReady, arReady, bValid, rValid, irq, pwm});
		for (int c = 0; c < pwmPkg::NumChannels; c++)
		begin
			readCheck(regAddr(c, pwmPkg::OffCtrl), 0, "ctrl");
			readCheck(regAddr(c, pwmPkg::OffDuty), 0, "duty");
			readCheck(regAddr(c, pwmPkg::OffDiv), 0, "div");
		end
		readCheck(pwmPkg::AddrStatus, 0, "status");
		readCheck(pwmPkg::AddrIrqEn, 0, "irqEn");
		for (int c = 0; c < pwmPkg::NumChannels; c++)
		begin
			v = $urandom;
			writeOk(regAddr(c, pwmPkg::OffDuty), v);
			readCheck(regAddr(c, pwmPkg::OffDuty), v & 32'hFF, "duty");   // Byte wide
			v = $urandom;
			writeOk(regAddr(c, pwmPkg::OffDiv), v);
			readCheck(regAddr(c, pwmPkg::OffDiv), v, "div");
			writeOk(regAddr(c, pwmPkg::OffCtrl), 32'h1234_5679);
			readCheck(regAddr(c, pwmPkg::OffCtrl), 1, "ctrl");
			writeOk(regAddr(c, pwmPkg::OffCtrl), 32'hFFFF_FFFE);
			readCheck(regAddr(c, pwmPkg::OffCtrl), 0, "ctrl");
		end
		writeOk(pwmPkg::AddrIrqEn, 32'hDEAD_BEE5);
		readCheck(pwmPkg::AddrIrqEn, 32'h5, "irqEn");              // One bit per channel
		writeOk(pwmPkg::AddrIrqEn, 0);
	endtask

	task automatic testDutyRatio();
		int highs;
		for (int c = 0; c < pwmPkg::NumChannels; c++)
		begin
			dutySet[c] = (c == pwmPkg::NumChannels - 1) ? 255 : $urandom % 256;
			divSet[c]  = $urandom % 4;
			writeOk(regAddr(c, pwmPkg::OffDiv), divSet[c]);
			writeOk(regAddr(c, pwmPkg::OffDuty), dutySet[c]);
			writeOk(regAddr(c, pwmPkg::OffCtrl), 1);
			repeat (256 * (divSet[c] + 1) + 4) @(negedge iSysClk);   // Settle one period
			countHigh(c, 256 * (divSet[c] + 1), highs);
			checkVal("pwm high cycles", (255 - dutySet[c]) * (divSet[c] + 1), highs);
		end
	endtask

	task automatic testDisable();
		int   highs [pwmPkg::NumChannels];
		logic seenHigh;
		seenHigh = 1'b0;
		foreach (highs[c])
			highs[c] = 0;
		writeOk(regAddr(0, pwmPkg::OffCtrl), 0);
		repeat (2) @(negedge iSysClk);
		checkVal("pwm[0] after disable", 0, pwm[0]);
		repeat (256 * 12)                   // Whole periods for every divisor 0 to 3
		begin
			@(negedge iSysClk);
			seenHigh |= pwm[0];
			for (int c = 1; c < pwmPkg::NumChannels; c++)
				if (pwm[c])
					highs[c]++;
		end
		checkVal("pwm[0] held low", 0, seenHigh);
		for (int c = 1; c < pwmPkg::NumChannels; c++)
			checkVal($sformatf("pwm[%0d] high cycles", c), (255 - dutySet[c]) * 12, highs[c]);
	endtask

	task automatic testStatusIrq();
		pwmPkg::dataT data;
		logic [1:0]   resp;
		logic         irqSeen;
		irqSeen = 1'b0;
		for (int c = 0; c < pwmPkg::NumChannels; c++)
			writeOk(regAddr(c, pwmPkg::OffCtrl), 0);
		writeOk(pwmPkg::AddrStatus, 32'hF);                      // Clear every flag
		readCheck(pwmPkg::AddrStatus, 0, "status");
		writeOk(regAddr(1, pwmPkg::OffDiv), 0);
		writeOk(regAddr(2, pwmPkg::OffDiv), 1);
		writeOk(pwmPkg::AddrIrqEn, 32'h4);                       // Channel 2 only
		writeOk(regAddr(1, pwmPkg::OffCtrl), 1);
		writeOk(regAddr(2, pwmPkg::OffCtrl), 1);
		awaitLevel("irq", 1'b1, 256 * 2 + 3);
		axiRead(pwmPkg::AddrStatus, data, resp);
		checkVal("status[2]", 1, data[2]);
		writeOk(regAddr(2, pwmPkg::OffCtrl), 0);
		writeOk(pwmPkg::AddrStatus, 32'h4);                      // W1C channel 2
		awaitLevel("irq", 1'b0, 4);
		axiRead(pwmPkg::AddrStatus, data, resp);
		checkVal("status[2] after clear", 0, data[2]);
		// Channel 1 keeps cycling with its interrupt masked
		repeat (256 + 4)
		begin
			@(negedge iSysClk);
			irqSeen |= irq;
		end
		checkVal("irq masked", 0, irqSeen);
		axiRead(pwmPkg::AddrStatus, data, resp);
		checkVal("status[1]", 1, data[1]);
	endtask

	task automatic testErrorBackPressure();
		pwmPkg::dataT data;
		logic [1:0]   resp;
		logic [1:0]   heldB;
		logic [1:0]   heldR;
		pwmPkg::dataT heldData;
		// Gap after channel 3 DIV
		axiRead(8'h3C, data, resp);
		checkVal("rData unmapped", 0, data);
		checkVal("rResp unmapped", pwmPkg::RespSlvErr, resp);
		axiWrite(8'h3C, 32'hFFFF_FFFF, resp);
		checkVal("bResp unmapped", pwmPkg::RespSlvErr, resp);
		// Write and read together with both responses stalled
		@(posedge iSysClk);
		bReady  <= 1'b0;
		rReady  <= 1'b0;
		awAddr  <= pwmPkg::AddrIrqEn;
		wData   <= 32'h3;
		awValid <= 1'b1;
		wValid  <= 1'b1;
		arAddr  <= pwmPkg::AddrIrqEn;
		arValid <= 1'b1;
		awaitLevel("awReady", 1'b1, 20);
		@(posedge iSysClk);
		arValid <= 1'b0;
		wData   <= 32'hC;                // Second write left pending
		awaitLevel("bValid", 1'b1, 20);
		awaitLevel("rValid", 1'b1, 20);
		heldB    = bResp;
		heldR    = rResp;
		heldData = rData;
		checkVal("bResp", pwmPkg::RespOkay, heldB);
		checkVal("rResp", pwmPkg::RespOkay, heldR);
		checkVal("rData", 32'h4, heldData);   // Mask from the status test
		repeat (5)
		begin
			@(negedge iSysClk);
			checkVal("bValid", 1, bValid);
			checkVal("bResp", heldB, bResp);
			checkVal("rValid", 1, rValid);
			checkVal("rResp", heldR, rResp);
			checkVal("rData", heldData, rData);
			checkVal("awReady", 0, awReady);
		end
		@(posedge iSysClk);
		awValid <= 1'b0;
		wValid  <= 1'b0;
		bReady  <= 1'b1;
		rReady  <= 1'b1;
		awaitLevel("bValid", 1'b0, 20);
		awaitLevel("rValid", 1'b0, 20);
		readCheck(pwmPkg::AddrIrqEn, 32'h3, "irqEn");             // Pending write dropped
	endtask

	//------------------------------------------------------------------
	// Main sequence
	//------------------------------------------------------------------
	initial
	begin
		iSysClk      = 1'b0;
		rstN         = 1'b0;
		awAddr       = '0;
		arAddr       = '0;
		wData        = '0;
		wStrb        = '1;
		awValid      = 1'b0;
		wValid       = 1'b0;
		arValid      = 1'b0;
		bReady       = 1'b1;
		rReady       = 1'b1;
		errCount     = 0;
		timeoutCount = 0;
		void'($urandom(32'h629a_9adc));
		repeat (3) @(posedge iSysClk);
		rstN <= 1'b1;
		@(negedge iSysClk);
		testRegisters();
		testDutyRatio();
		testDisable();
		testStatusIrq();
		testErrorBackPressure();
		$display("Errors: %0d value mismatches, %0d timeouts", errCount, timeoutCount);
		if (errCount == 0 && timeoutCount == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

/* tests/pwmSubsystem_properties.sv */
//----------------------------------------------------------------------
// PWM subsystem bus properties
// Response hold, write accept exclusion, quiet outputs in reset
//----------------------------------------------------------------------
module pwmSubsystemProperties (
	input logic             iSysClk,
	input logic             rstN,
	input logic             awReady,
	input logic             bValid,
	input logic             bReady,
	input logic [1:0]       bResp,
	input logic             rValid,
	input logic             rReady,
	input logic [1:0]       rResp,
	input pwmPkg::dataT     rData,
	input pwmPkg::chanMaskT pwm,
	input logic             irq
);
	timeunit 1ns;
	timeprecision 1ps;

	// Write response held with a stable code until bReady
	bHold: assert property (@(posedge iSysClk) disable iff (!rstN)
		bValid && !bReady |=> bValid && $stable(bResp))
		else $error("Write response dropped or changed before bReady");

	// Read response held with stable data until rReady
	rHold: assert property (@(posedge iSysClk) disable iff (!rstN)
		rValid && !rReady |=> rValid && $stable(rData) && $stable(rResp))
		else $error("Read response dropped or changed before rReady");

	// No new write while a response is pending
	awBlock: assert property (@(posedge iSysClk) disable iff (!rstN)
		!(awReady && bValid))
		else $error("Write accepted while bValid is high");

	// Outputs quiet once reset has been seen for a cycle
	resetQuiet: assert property (@(posedge iSysClk)
		!rstN && $past(!rstN) |-> (pwm == '0) && !irq)
		else $error("PWM or interrupt active during reset");

endmodule

bind pwmSubsystem pwmSubsystemProperties props (.*);

/* src/pwmSubsystem.sv */
//----------------------------------------------------------------------
// Four channel PWM subsystem
// AXI4-Lite register bank driving independent PWM channels
//----------------------------------------------------------------------
module pwmSubsystem (
	input  logic                           iSysClk,
	input  logic                           rstN,
	// AXI4-Lite write
	input  pwmPkg::addrT                   awAddr,
	input  logic                           awValid,
	output logic                           awReady,
	input  pwmPkg::dataT                   wData,
	input  logic [pwmPkg::DataWidth/8-1:0] wStrb,
	input  logic                           wValid,
	output logic                           wReady,
	output logic [1:0]                     bResp,
	output logic                           bValid,
	input  logic                           bReady,
	// AXI4-Lite read
	input  pwmPkg::addrT                   arAddr,
	input  logic                           arValid,
	output logic                           arReady,
	output pwmPkg::dataT                   rData,
	output logic [1:0]                     rResp,
	output logic                           rValid,
	input  logic                           rReady,
	// Outputs
	output pwmPkg::chanMaskT               pwm,     // One bit per channel
	output logic                           irq      // Any enabled status flag
);

	// Bank to channel links
	pwmChanIf chanIf [pwmPkg::NumChannels] ();

	//------------------------------------------------------------------
	// Register bank
	//------------------------------------------------------------------
	pwmRegBank regBank (
		.iSysClk (iSysClk),
		.rstN    (rstN),
		.awAddr  (awAddr),
		.awValid (awValid),
		.awReady (awReady),
		.wData   (wData),
		.wStrb   (wStrb),
		.wValid  (wValid),
		.wReady  (wReady),
		.bResp   (bResp),
		.bValid  (bValid),
		.bReady  (bReady),
		.arAddr  (arAddr),
		.arValid (arValid),
		.arReady (arReady),
		.rData   (rData),
		.rResp   (rResp),
		.rValid  (rValid),
		.rReady  (rReady),
		.chan    (chanIf),
		.irq     (irq)
	);

	//------------------------------------------------------------------
	// Channels
	//------------------------------------------------------------------
	for (genvar g = 0; g < pwmPkg::NumChannels; g++)
	begin : genChan
		dutyGenerator chanGen (
			.iSysClk (iSysClk),
			.rstN    (rstN),
			.cfg     (chanIf[g]),
			.pwm     (pwm[g])      // Collected into the output mask
		);
	end

endmodule

/* src/pwmRegBank.sv */
//----------------------------------------------------------------------
// PWM register bank
// AXI4-Lite slave holding channel config, sticky status, interrupt
// enables and the interrupt line
//----------------------------------------------------------------------
module pwmRegBank (
	input  logic                           iSysClk,
	input  logic                           rstN,
	// Write channels
	input  pwmPkg::addrT                   awAddr,
	input  logic                           awValid,
	output logic                           awReady,
	input  pwmPkg::dataT                   wData,
	input  logic [pwmPkg::DataWidth/8-1:0] wStrb,
	input  logic                           wValid,
	output logic                           wReady,
	output logic [1:0]                     bResp,
	output logic                           bValid,
	input  logic                           bReady,
	// Read channels
	input  pwmPkg::addrT                   arAddr,
	input  logic                           arValid,
	output logic                           arReady,
	output pwmPkg::dataT                   rData,
	output logic [1:0]                     rResp,
	output logic                           rValid,
	input  logic                           rReady,
	// Channel config
	pwmChanIf.bank                         chan [pwmPkg::NumChannels],
	output logic                           irq
);

	pwmPkg::regStateT wrState;    // Write FSM
	pwmPkg::regStateT rdState;    // Read FSM
	pwmPkg::axiRespT  bRespQ;
	pwmPkg::axiRespT  rRespQ;
	pwmPkg::dataT     rDataQ;
	pwmPkg::dataT     rdWord;     // Read mux output

	pwmPkg::chanMaskT ctrlEn;                          // Channel enables
	pwmPkg::dutyT     dutyReg [pwmPkg::NumChannels];
	pwmPkg::divT      divReg  [pwmPkg::NumChannels];
	pwmPkg::chanMaskT status;     // Sticky cycle done
	pwmPkg::chanMaskT irqEn;
	pwmPkg::chanMaskT doneVec;    // Cycle pulses from channels
	pwmPkg::chanMaskT clrMask;    // W1C bits this cycle

	logic wrFire;                 // Write handshake
	logic wrEn;                   // Handshake carrying data
	logic rdFire;                 // Read address handshake

	//------------------------------------------------------------------
	// Address decode helpers
	//------------------------------------------------------------------
	function automatic pwmPkg::addrT chanAddr(input int c, input int off);
		return pwmPkg::addrT'(c * pwmPkg::ChanStride + off);
	endfunction

	function automatic logic isMapped(input pwmPkg::addrT a);
		logic hit;
		hit = (a == pwmPkg::AddrStatus) || (a == pwmPkg::AddrIrqEn);
		for (int c = 0; c < pwmPkg::NumChannels; c++)
		begin
			hit |= (a == chanAddr(c, pwmPkg::OffCtrl));
			hit |= (a == chanAddr(c, pwmPkg::OffDuty));
			hit |= (a == chanAddr(c, pwmPkg::OffDiv));
		end
		return hit;
	endfunction

	//------------------------------------------------------------------
	// Channel fan out
	//------------------------------------------------------------------
	for (genvar g = 0; g < pwmPkg::NumChannels; g++)
	begin : genChanLink
		assign chan[g].enable  = ctrlEn[g];
		assign chan[g].duty    = dutyReg[g];
		assign chan[g].divisor = divReg[g];
		assign doneVec[g]      = chan[g].cycleDone;
	end

	//------------------------------------------------------------------
	// Write path
	//------------------------------------------------------------------
	assign wrFire  = (wrState == pwmPkg::Idle) && awValid && wValid;
	assign awReady = wrFire;                // Both ready for one cycle
	assign wReady  = wrFire;
	assign wrEn    = wrFire && (|wStrb);    // Any lane writes the word
	assign bValid  = (wrState == pwmPkg::Resp);
	assign bResp   = bRespQ;

	always_ff @(posedge iSysClk or negedge rstN)
	begin
		if (!rstN)
			wrState <= pwmPkg::Idle;
		else
		begin
			case (wrState)
				pwmPkg::Idle: if (wrFire) wrState <= pwmPkg::Resp;
				pwmPkg::Resp: if (bReady) wrState <= pwmPkg::Idle;
				default:      wrState <= pwmPkg::Idle;
			endcase
		end
	end

	// Response code captured with the handshake
	always_ff @(posedge iSysClk)
	begin
		if (wrFire)
			bRespQ <= isMapped(awAddr) ? pwmPkg::RespOkay : pwmPkg::RespSlvErr;
	end

	// Config registers
	always_ff @(posedge iSysClk or negedge rstN)
	begin
		if (!rstN)
		begin
			ctrlEn <= '0;
			irqEn  <= '0;
			for (int c = 0; c < pwmPkg::NumChannels; c++)
			begin
				dutyReg[c] <= '0;
				divReg[c]  <= '0;
			end
		end
		else if (wrEn)
		begin
			if (awAddr == pwmPkg::AddrIrqEn)
				irqEn <= wData[pwmPkg::NumChannels-1:0];
			for (int c = 0; c < pwmPkg::NumChannels; c++)
			begin
				if (awAddr == chanAddr(c, pwmPkg::OffCtrl))
					ctrlEn[c] <= wData[0];
				if (awAddr == chanAddr(c, pwmPkg::OffDuty))
					dutyReg[c] <= wData[pwmPkg::DutyWidth-1:0];
				if (awAddr == chanAddr(c, pwmPkg::OffDiv))
					divReg[c] <= wData;
			end
		end
	end

	//------------------------------------------------------------------
	// Status and interrupt
	//------------------------------------------------------------------
	assign clrMask = (wrEn && awAddr == pwmPkg::AddrStatus) ?
		wData[pwmPkg::NumChannels-1:0] : '0;

	always_ff @(posedge iSysClk or negedge rstN)
	begin
		if (!rstN)
		begin
			status <= '0;
			irq    <= 1'b0;
		end
		else
		begin
			status <= (status & ~clrMask) | doneVec;  // Set wins over clear
			irq    <= |(status & irqEn);
		end
	end

	//------------------------------------------------------------------
	// Read path
	//------------------------------------------------------------------
	assign rdFire  = (rdState == pwmPkg::Idle) && arValid;
	assign arReady = rdFire;
	assign rValid  = (rdState == pwmPkg::Resp);
	assign rData   = rDataQ;
	assign rResp   = rRespQ;

	// Read mux, zero for unmapped addresses
	always_comb
	begin
		rdWord = '0;
		if (arAddr == pwmPkg::AddrStatus)
			rdWord = pwmPkg::dataT'(status);
		if (arAddr == pwmPkg::AddrIrqEn)
			rdWord = pwmPkg::dataT'(irqEn);
		for (int c = 0; c < pwmPkg::NumChannels; c++)
		begin
			if (arAddr == chanAddr(c, pwmPkg::OffCtrl))
				rdWord = pwmPkg::dataT'(ctrlEn[c]);
			if (arAddr == chanAddr(c, pwmPkg::OffDuty))
				rdWord = pwmPkg::dataT'(dutyReg[c]);
			if (arAddr == chanAddr(c, pwmPkg::OffDiv))
				rdWord = divReg[c];
		end
	end

	always_ff @(posedge iSysClk or negedge rstN)
	begin
		if (!rstN)
			rdState <= pwmPkg::Idle;
		else
		begin
			case (rdState)
				pwmPkg::Idle: if (rdFire) rdState <= pwmPkg::Resp;
				pwmPkg::Resp: if (rReady) rdState <= pwmPkg::Idle;
				default:      rdState <= pwmPkg::Idle;
			endcase
		end
	end

	// Read data held until rReady
	always_ff @(posedge iSysClk)
	begin
		if (rdFire)
		begin
			rDataQ <= rdWord;
			rRespQ <= isMapped(arAddr) ? pwmPkg::RespOkay : pwmPkg::RespSlvErr;
		end
	end

endmodule

/* src/dutyGenerator.sv */
//----------------------------------------------------------------------
// PWM duty generator
// Divided rate 8-bit counter, compare against duty, cycle done pulse
//----------------------------------------------------------------------
module dutyGenerator (
	input  logic   iSysClk,
	input  logic   rstN,
	pwmChanIf.chan cfg,        // Config in, cycle event out
	output logic   pwm         // Registered PWM output
);

	logic         tick;        // Counter step enable
	pwmPkg::dutyT dutyCnt;     // Position within the PWM period
	pwmPkg::dutyT nextCnt;     // Counter after one step
	logic         doneQ;       // Registered cycle event

	//------------------------------------------------------------------
	// Counter rate
	//------------------------------------------------------------------
	clkEnableDivider rateDiv (
		.iSysClk (iSysClk),
		.rstN    (rstN),
		.enable  (cfg.enable),
		.divisor (cfg.divisor),
		.tick    (tick)
	);

	//------------------------------------------------------------------
	// Duty counter
	//------------------------------------------------------------------
	assign nextCnt = dutyCnt + 1'b1;   // Natural wrap 255 to 0

	always_ff @(posedge iSysClk or negedge rstN)
	begin
		if (!rstN)
			dutyCnt <= '0;
		else if (!cfg.enable)
			dutyCnt <= '0;             // Held at zero while stopped
		else if (tick)
			dutyCnt <= nextCnt;
	end

	//------------------------------------------------------------------
	// Compare and cycle event
	//------------------------------------------------------------------
	always_ff @(posedge iSysClk or negedge rstN)
	begin
		if (!rstN)
		begin
			pwm   <= 1'b0;
			doneQ <= 1'b0;
		end
		else
		begin
			// High for counter values above duty
			pwm   <= cfg.enable && (dutyCnt > cfg.duty);
			// Step into the last count value ends a full cycle
			doneQ <= tick && (&nextCnt);
		end
	end

	assign cfg.cycleDone = doneQ;  // One cycle wide

endmodule

/* src/clkEnableDivider.sv */
//----------------------------------------------------------------------
// Clock enable divider
// One cycle tick every divisor+1 cycles while enabled
//----------------------------------------------------------------------
module clkEnableDivider (
	input  logic        iSysClk,
	input  logic        rstN,
	input  logic        enable,    // Run the divider
	input  pwmPkg::divT divisor,   // Tick period minus one
	output logic        tick       // Single cycle rate enable
);

	pwmPkg::divT count;     // Cycles left before the next tick
	logic        running;   // Loaded at least once since enable

	// Tick while the down counter sits at zero
	assign tick = enable && running && (count == '0);

	always_ff @(posedge iSysClk or negedge rstN)
	begin
		if (!rstN)
		begin
			count   <= '0;
			running <= 1'b0;
		end
		else if (!enable)
		begin
			count   <= '0;       // Fresh start on next enable
			running <= 1'b0;
		end
		else if (!running || count == '0)
		begin
			// Reload point, a new divisor takes effect here
			count   <= divisor;
			running <= 1'b1;
		end
		else
		begin
			count <= count - 1'b1;
		end
	end

endmodule

/* src/pwmChanIf.sv */
//----------------------------------------------------------------------
// PWM channel link
// Configuration from the register bank and cycle event back from
// one channel
//----------------------------------------------------------------------
interface pwmChanIf;

	logic         enable;     // Channel run
	pwmPkg::dutyT duty;       // Compare value
	pwmPkg::divT  divisor;    // Counter step period minus one
	logic         cycleDone;  // One cycle pulse per full counter cycle

	// Register bank side
	modport bank (
		output enable,
		output duty,
		output divisor,
		input  cycleDone
	);

	// Channel side
	modport chan (
		input  enable,
		input  duty,
		input  divisor,
		output cycleDone
	);

endinterface

/* src/pwmPkg.sv */
//----------------------------------------------------------------------
// PWM controller shared definitions
// Widths, channel count, register map and common types
//----------------------------------------------------------------------
package pwmPkg;

	//------------------------------------------------------------------
	// Widths
	//------------------------------------------------------------------
	localparam int NumChannels = 4;    // PWM channels in the subsystem
	localparam int DutyWidth   = 8;    // Duty counter resolution
	localparam int DivWidth    = 32;   // Rate divider width
	localparam int AddrWidth   = 8;    // AXI4-Lite address bits
	localparam int DataWidth   = 32;   // AXI4-Lite data bits

	// Vector types
	typedef logic [DutyWidth-1:0]   dutyT;      // Duty setting or counter value
	typedef logic [DivWidth-1:0]    divT;       // Divider reload value
	typedef logic [AddrWidth-1:0]   addrT;      // Register byte address
	typedef logic [DataWidth-1:0]   dataT;      // Register word
	typedef logic [NumChannels-1:0] chanMaskT;  // One bit per channel

	//------------------------------------------------------------------
	// Register map
	//------------------------------------------------------------------
	// Per channel block, channel c based at c * ChanStride
	localparam int ChanStride = 16;
	localparam int OffCtrl    = 0;     // Bit 0 enable
	localparam int OffDuty    = 4;     // Low byte duty
	localparam int OffDiv     = 8;     // Full word divider

	// Global registers above the channel blocks
	localparam addrT AddrStatus = 8'h40;  // Sticky cycle done, W1C
	localparam addrT AddrIrqEn  = 8'h44;  // Interrupt enables

	//------------------------------------------------------------------
	// Enums
	//------------------------------------------------------------------
	// AXI response encoding
	typedef enum logic [1:0] {
		RespOkay   = 2'b00,
		RespSlvErr = 2'b10
	} axiRespT;

	// Bank handshake FSM states
	typedef enum logic {
		Idle = 1'b0,    // Waiting for a request
		Resp = 1'b1     // Response held until accepted
	} regStateT;

endpackage
